// ==== sim.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_tag_lookup.sv
verilog/dcache_plru.sv
verilog/dcache_data_array.sv
verilog/dcache_miss_ctrl.sv
verilog/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

// ==== testbench/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int     NUM_ROWS        = 26;
    localparam int     WATCHDOG_CYCLES = NUM_ROWS * 200;
    localparam int     MEM_WORDS       = 16384;
    localparam index_t SET_A           = 4'd3;
    localparam index_t SET_B           = 4'd7;

    logic         clk;
    logic         resetn;
    logic         dreq_valid;
    logic [31:0]  dreq_addr;
    strobe_t      dreq_strobe;
    word_t        dreq_wdata;
    logic         addr_ok;
    logic         data_ok;
    word_t        rdata;
    logic         creq_valid;
    logic         creq_is_write;
    logic [31:0]  creq_addr;
    word_t        creq_wdata;
    logic         cresp_ready;
    logic         cresp_last;
    word_t        cresp_rdata;
    logic [31:0]  fetch_count;
    logic [31:0]  wb_count;
    logic [31:0]  wb_addr;
    logic [127:0] wb_line;

    // stimulus and expected responses
    logic [31:0]  row_addr    [NUM_ROWS];
    strobe_t      row_strobe  [NUM_ROWS];
    word_t        row_wdata   [NUM_ROWS];
    word_t        row_rdata   [NUM_ROWS];
    logic         row_hit     [NUM_ROWS];
    logic [31:0]  row_fetches [NUM_ROWS];
    logic [31:0]  row_wbs     [NUM_ROWS];
    logic         row_wb      [NUM_ROWS];
    logic [31:0]  row_wb_addr [NUM_ROWS];
    logic [127:0] row_wb_line [NUM_ROWS];
    int           n_rows;

    // reference model of memory contents and cache state
    word_t        shadow  [MEM_WORDS];
    logic         m_valid [`DC_SETS][`DC_WAYS];
    logic         m_dirty [`DC_SETS][`DC_WAYS];
    tag_t         m_tag   [`DC_SETS][`DC_WAYS];
    logic [2:0]   m_plru  [`DC_SETS];
    int           fetch_total;
    int           wb_total;

    dcache_top u_dcache_top (
        .clk           (clk),
        .resetn        (resetn),
        .dreq_valid    (dreq_valid),
        .dreq_addr     (dreq_addr),
        .dreq_strobe   (dreq_strobe),
        .dreq_wdata    (dreq_wdata),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rdata         (rdata),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_wdata    (creq_wdata),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_rdata   (cresp_rdata)
    );

    tb_mem_model u_mem_model (
        .clk           (clk),
        .resetn        (resetn),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_wdata    (creq_wdata),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_rdata   (cresp_rdata),
        .fetch_count   (fetch_count),
        .wb_count      (wb_count),
        .wb_addr       (wb_addr),
        .wb_line       (wb_line)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] make_addr(input tag_t tag, input index_t idx,
                                              input offset_t off);
        return {tag, idx, off, 2'b00};
    endfunction

    // bit 0 is the root, bit 1 the low-half node, bit 2 the high-half node
    // each bit names the half that holds the next victim
    function automatic way_t plru_victim(input logic [2:0] t);
        return {t[0], t[0] ? t[2] : t[1]};
    endfunction

    function automatic logic [2:0] plru_touch(input logic [2:0] t, input way_t w);
        logic [2:0] r;
        r    = t;
        r[0] = ~w[1];
        if (w[1]) begin
            r[2] = ~w[0];
        end else begin
            r[1] = ~w[0];
        end
        return r;
    endfunction

    function automatic logic [127:0] shadow_line(input logic [31:0] line_addr);
        logic [127:0] line;
        int           base;
        base = int'(line_addr >> 2);
        for (int k = 0; k < `DC_LINE_WORDS; k++) begin
            line[k*32 +: 32] = shadow[base + k];
        end
        return line;
    endfunction

    // one access through the reference model, recording what the DUT must do
    task automatic add_row(input tag_t tag, input index_t idx, input offset_t off,
                           input strobe_t strb, input word_t wdata);
        logic [31:0] addr;
        int          widx;
        way_t        w;
        logic        found;
        addr  = make_addr(tag, idx, off);
        widx  = int'(addr >> 2);
        found = 1'b0;
        w     = '0;
        for (int k = 0; k < `DC_WAYS; k++) begin
            if (m_valid[idx][k] && m_tag[idx][k] == tag) begin
                found = 1'b1;
                w     = way_t'(k);
            end
        end
        row_hit[n_rows]     = found;
        row_wb[n_rows]      = 1'b0;
        row_wb_addr[n_rows] = '0;
        row_wb_line[n_rows] = '0;
        if (!found) begin
            w = plru_victim(m_plru[idx]);
            fetch_total++;
            if (m_valid[idx][w] && m_dirty[idx][w]) begin
                wb_total++;
                row_wb[n_rows]      = 1'b1;
                row_wb_addr[n_rows] = make_addr(m_tag[idx][w], idx, '0);
                row_wb_line[n_rows] = shadow_line(row_wb_addr[n_rows]);
            end
            m_valid[idx][w] = 1'b1;
            m_dirty[idx][w] = 1'b0;
            m_tag[idx][w]   = tag;
        end
        m_plru[idx]       = plru_touch(m_plru[idx], w);
        row_rdata[n_rows] = shadow[widx];
        for (int k = 0; k < `DC_STRB_BITS; k++) begin
            if (strb[k]) begin
                shadow[widx][k*8 +: 8] = wdata[k*8 +: 8];
            end
        end
        if (|strb) begin
            m_dirty[idx][w] = 1'b1;
        end
        row_addr[n_rows]    = addr;
        row_strobe[n_rows]  = strb;
        row_wdata[n_rows]   = wdata;
        row_fetches[n_rows] = fetch_total;
        row_wbs[n_rows]     = wb_total;
        n_rows++;
    endtask

    task automatic build_table();
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = i ^ 32'h5a5a_0000;
        end
        for (int s = 0; s < `DC_SETS; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        n_rows      = 0;
        fetch_total = 0;
        wb_total    = 0;
        // fill and repeat reads, then merge partial writes
        add_row(24'h10, SET_A, 2'd1, 4'b0000, 32'h0);
        add_row(24'h10, SET_A, 2'd1, 4'b0000, 32'h0);
        add_row(24'h10, SET_A, 2'd2, 4'b0000, 32'h0);
        add_row(24'h10, SET_A, 2'd1, 4'b0011, 32'h1122_3344);
        add_row(24'h10, SET_A, 2'd1, 4'b1100, 32'haabb_ccdd);
        add_row(24'h10, SET_A, 2'd1, 4'b0000, 32'h0);
        add_row(24'h10, SET_A, 2'd3, 4'b0100, 32'h00ee_0000);
        add_row(24'h20, SET_A, 2'd0, 4'b0000, 32'h0);
        add_row(24'h20, SET_A, 2'd2, 4'b1111, 32'hdead_beef);
        add_row(24'h30, SET_A, 2'd1, 4'b0000, 32'h0);
        add_row(24'h40, SET_A, 2'd3, 4'b0000, 32'h0);
        add_row(24'h20, SET_A, 2'd2, 4'b0000, 32'h0);
        // fifth tag evicts a dirty line, then the evicted lines come back
        add_row(24'h50, SET_A, 2'd0, 4'b0000, 32'h0);
        add_row(24'h10, SET_A, 2'd1, 4'b0000, 32'h0);
        add_row(24'h10, SET_A, 2'd3, 4'b0000, 32'h0);
        add_row(24'h60, SET_A, 2'd0, 4'b0000, 32'h0);
        add_row(24'h70, SET_A, 2'd0, 4'b0000, 32'h0);
        add_row(24'h20, SET_A, 2'd2, 4'b0000, 32'h0);
        // eviction of a clean line writes nothing back
        add_row(24'h01, SET_B, 2'd0, 4'b0000, 32'h0);
        add_row(24'h02, SET_B, 2'd1, 4'b0000, 32'h0);
        add_row(24'h03, SET_B, 2'd2, 4'b0000, 32'h0);
        add_row(24'h04, SET_B, 2'd3, 4'b0000, 32'h0);
        add_row(24'h05, SET_B, 2'd0, 4'b0000, 32'h0);
        add_row(24'h01, SET_B, 2'd0, 4'b0000, 32'h0);
        add_row(24'h06, SET_B, 2'd1, 4'b0001, 32'h0000_00a5);
        add_row(24'h06, SET_B, 2'd1, 4'b0000, 32'h0);
    endtask

    task automatic apply_row(input int r);
        @(posedge clk);
        dreq_valid  <= 1'b1;
        dreq_addr   <= row_addr[r];
        dreq_strobe <= row_strobe[r];
        dreq_wdata  <= row_wdata[r];
        @(negedge clk);
        // a hit is taken in its first cycle, a miss never is
        check("addr_ok", addr_ok, row_hit[r]);
        check("data_ok", data_ok, 1'b0);
        while (addr_ok !== 1'b1) begin
            @(negedge clk);
        end
        // request is taken at this edge
        @(posedge clk);
        dreq_valid  <= 1'b0;
        dreq_strobe <= '0;
        @(negedge clk);
        check("data_ok", data_ok, 1'b1);
        if (row_strobe[r] == '0) begin
            check("rdata", rdata, row_rdata[r]);
        end
        check("fetch_count", fetch_count, row_fetches[r]);
        check("wb_count", wb_count, row_wbs[r]);
        if (row_wb[r]) begin
            check("wb_addr", wb_addr, row_wb_addr[r]);
            check("wb_line", wb_line, row_wb_line[r]);
        end
    endtask

    initial begin
        resetn      = 1'b1;
        dreq_valid  = 1'b0;
        dreq_addr   = '0;
        dreq_strobe = '0;
        dreq_wdata  = '0;
        build_table();
        if (n_rows != NUM_ROWS) begin
            $display("stimulus table holds %0d rows instead of %0d", n_rows, NUM_ROWS);
            $display("STATUS: FAIL");
            $fatal(1, "stimulus table has the wrong size");
        end
        repeat (2) @(posedge clk);
        resetn <= 1'b0;
        @(negedge clk);
        check("data_ok", data_ok, 1'b0);
        check("creq_valid", creq_valid, 1'b0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
        end
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== testbench/tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module tb_mem_model (
    input  wire logic         clk,
    input  wire logic         resetn,
    input  wire logic         creq_valid,
    input  wire logic         creq_is_write,
    input  wire logic [31:0]  creq_addr,
    input  wire logic [31:0]  creq_wdata,
    output logic              cresp_ready,
    output logic              cresp_last,
    output logic [31:0]       cresp_rdata,
    output logic [31:0]       fetch_count,
    output logic [31:0]       wb_count,
    output logic [31:0]       wb_addr,
    output logic [127:0]      wb_line
);
    localparam int MEM_WORDS = 16384;

    logic [31:0]                mem [MEM_WORDS];
    logic                       written [MEM_WORDS];
    logic [`DC_OFFSET_BITS-1:0] beat;
    integer                     seed;

    // never-written words read back as a pattern of their own address
    function automatic logic [31:0] read_word(input logic [31:0] waddr);
        if (waddr < MEM_WORDS && written[waddr]) begin
            return mem[waddr];
        end
        return waddr ^ 32'h5a5a_0000;
    endfunction

    initial begin
        seed        = 32'h348c_d528;
        cresp_ready = 1'b0;
        cresp_last  = 1'b0;
        cresp_rdata = '0;
        fetch_count = '0;
        wb_count    = '0;
        wb_addr     = '0;
        wb_line     = '0;
        beat        = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            written[i] = 1'b0;
        end
    end

    // response signals are set one cycle ahead from the request seen at this edge
    always @(posedge clk) begin
        logic [`DC_OFFSET_BITS-1:0] beat_n;
        logic                       done;
        logic                       ready_n;
        logic [31:0]                waddr;
        logic [31:0]                rnd;
        if (resetn) begin
            cresp_ready <= 1'b0;
            cresp_last  <= 1'b0;
            cresp_rdata <= '0;
            fetch_count <= '0;
            wb_count    <= '0;
            beat        <= '0;
        end else begin
            rnd    = $random(seed);
            beat_n = beat;
            done   = 1'b0;
            if (creq_valid && cresp_ready) begin
                waddr = {2'b00, creq_addr[31:2]} + 32'(beat);
                if (creq_is_write) begin
                    mem[waddr]                     <= creq_wdata;
                    written[waddr]                 <= 1'b1;
                    wb_line[int'(beat) * 32 +: 32] <= creq_wdata;
                    if (beat == '0) begin
                        wb_addr <= creq_addr;
                        $display("%0t mem: write-back of line %h", $time, creq_addr);
                    end
                end
                if (beat == `DC_OFFSET_BITS'(`DC_LINE_WORDS - 1)) begin
                    done   = 1'b1;
                    beat_n = '0;
                    if (creq_is_write) begin
                        wb_count <= wb_count + 1;
                    end else begin
                        fetch_count <= fetch_count + 1;
                    end
                end else begin
                    beat_n = beat + 1'b1;
                end
            end
            // ready about three cycles in four, never right after a burst ends
            ready_n     = creq_valid && !done && (rnd[1:0] != 2'b00);
            beat        <= beat_n;
            cresp_ready <= ready_n;
            cresp_last  <= ready_n && (beat_n == `DC_OFFSET_BITS'(`DC_LINE_WORDS - 1));
            cresp_rdata <= read_word({2'b00, creq_addr[31:2]} + 32'(beat_n));
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_top (
    input  wire logic                clk,
    input  wire logic                resetn,
    input  wire logic                dreq_valid,
    input  wire logic [31:0]         dreq_addr,
    input  wire dcache_pkg::strobe_t dreq_strobe,
    input  wire dcache_pkg::word_t   dreq_wdata,
    output logic                     addr_ok,
    output logic                     data_ok,
    output dcache_pkg::word_t        rdata,
    output logic                     creq_valid,
    output logic                     creq_is_write,
    output logic [31:0]              creq_addr,
    output dcache_pkg::word_t        creq_wdata,
    input  wire logic                cresp_ready,
    input  wire logic                cresp_last,
    input  wire dcache_pkg::word_t   cresp_rdata
);
    import dcache_pkg::*;

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    logic    req_write;
    logic    hit;
    way_t    hit_way;
    logic    miss;
    way_t    victim_way;
    logic    victim_dirty;
    tag_t    victim_tag;
    logic    engine_idle;
    logic    refill_done;
    logic    b_en;
    way_t    b_way;
    offset_t b_offset;
    strobe_t b_strobe;
    word_t   b_wdata;
    word_t   b_rdata;

    // tag | index | word offset | byte
    assign req_tag    = dreq_addr[31 -: `DC_TAG_BITS];
    assign req_index  = dreq_addr[2 + `DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign req_offset = dreq_addr[2 +: `DC_OFFSET_BITS];
    assign req_write  = |dreq_strobe;

    // hits only while the miss engine leaves the arrays alone
    assign addr_ok = hit && engine_idle;

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= addr_ok;
        end
    end

    dcache_tag_lookup u_lookup (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (dreq_valid),
        .req_tag      (req_tag),
        .req_index    (req_index),
        .req_write    (req_write),
        .engine_idle  (engine_idle),
        .refill_done  (refill_done),
        .victim_way   (victim_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .miss         (miss),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_plru u_plru (
        .clk        (clk),
        .resetn     (resetn),
        .index      (req_index),
        .touch      (addr_ok),
        .touch_way  (hit_way),
        .victim_way (victim_way)
    );

    dcache_data_array u_data (
        .clk      (clk),
        .a_en     (addr_ok),
        .a_way    (hit_way),
        .a_index  (req_index),
        .a_offset (req_offset),
        .a_strobe (dreq_strobe),
        .a_wdata  (dreq_wdata),
        .a_rdata  (rdata),
        .b_en     (b_en),
        .b_way    (b_way),
        .b_index  (req_index),
        .b_offset (b_offset),
        .b_strobe (b_strobe),
        .b_wdata  (b_wdata),
        .b_rdata  (b_rdata)
    );

    dcache_miss_ctrl u_miss (
        .clk           (clk),
        .resetn        (resetn),
        .miss          (miss),
        .req_tag       (req_tag),
        .req_index     (req_index),
        .victim_way    (victim_way),
        .victim_dirty  (victim_dirty),
        .victim_tag    (victim_tag),
        .b_rdata       (b_rdata),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_rdata   (cresp_rdata),
        .engine_idle   (engine_idle),
        .refill_done   (refill_done),
        .b_en          (b_en),
        .b_way         (b_way),
        .b_offset      (b_offset),
        .b_strobe      (b_strobe),
        .b_wdata       (b_wdata),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_wdata    (creq_wdata)
    );

endmodule

`default_nettype wire

// ==== verilog/dcache_miss_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_miss_ctrl (
    input  wire logic                clk,
    input  wire logic                resetn,
    input  wire logic                miss,
    input  wire dcache_pkg::tag_t    req_tag,
    input  wire dcache_pkg::index_t  req_index,
    input  wire dcache_pkg::way_t    victim_way,
    input  wire logic                victim_dirty,
    input  wire dcache_pkg::tag_t    victim_tag,
    input  wire dcache_pkg::word_t   b_rdata,
    input  wire logic                cresp_ready,
    input  wire logic                cresp_last,
    input  wire dcache_pkg::word_t   cresp_rdata,
    output logic                     engine_idle,
    output logic                     refill_done,
    output logic                     b_en,
    output dcache_pkg::way_t         b_way,
    output dcache_pkg::offset_t      b_offset,
    output dcache_pkg::strobe_t      b_strobe,
    output dcache_pkg::word_t        b_wdata,
    output logic                     creq_valid,
    output logic                     creq_is_write,
    output logic [31:0]              creq_addr,
    output dcache_pkg::word_t        creq_wdata
);
    import dcache_pkg::*;

    miss_state_t              state_q;
    // readout needs one count past the last word for the read latency
    logic [`DC_OFFSET_BITS:0] cnt_q;
    offset_t                  beat;
    way_t                     way_q;
    tag_t                     wb_tag_q;
    word_t                    line_buf [`DC_LINE_WORDS];

    assign beat = cnt_q[`DC_OFFSET_BITS-1:0];

    always_ff @(posedge clk) begin
        if (resetn) begin
            state_q <= MS_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                MS_IDLE: begin
                    if (miss) begin
                        state_q <= victim_dirty ? MS_READOUT : MS_FETCH;
                        cnt_q   <= '0;
                    end
                end
                MS_READOUT: begin
                    if (cnt_q == `DC_LINE_WORDS) begin
                        state_q <= MS_WRITEBACK;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                MS_WRITEBACK: begin
                    if (cresp_ready) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cresp_last) begin
                            state_q <= MS_FETCH;
                            cnt_q   <= '0;
                        end
                    end
                end
                MS_FETCH: begin
                    if (cresp_ready) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cresp_last) begin
                            state_q <= MS_IDLE;
                            cnt_q   <= '0;
                        end
                    end
                end
                default: begin
                    state_q <= MS_IDLE;
                end
            endcase
        end
    end

    // victim captured at the miss, line buffer one cycle behind the read
    always_ff @(posedge clk) begin
        if (state_q == MS_IDLE && miss) begin
            way_q    <= victim_way;
            wb_tag_q <= victim_tag;
        end
        if (state_q == MS_READOUT && cnt_q != '0) begin
            line_buf[offset_t'(cnt_q - 1'b1)] <= b_rdata;
        end
    end

    assign engine_idle = (state_q == MS_IDLE);
    assign refill_done = (state_q == MS_FETCH) && cresp_ready && cresp_last;

    // port B: reads during readout, full-word writes during fetch
    assign b_en     = ((state_q == MS_READOUT) && (cnt_q < `DC_LINE_WORDS))
                   || ((state_q == MS_FETCH) && cresp_ready);
    assign b_way    = way_q;
    assign b_offset = beat;
    assign b_strobe = {`DC_STRB_BITS{state_q == MS_FETCH}};
    assign b_wdata  = cresp_rdata;

    assign creq_valid    = (state_q == MS_WRITEBACK) || (state_q == MS_FETCH);
    assign creq_is_write = (state_q == MS_WRITEBACK);
    assign creq_addr     = {creq_is_write ? wb_tag_q : req_tag, req_index,
                            {(`DC_OFFSET_BITS + 2){1'b0}}};
    assign creq_wdata    = line_buf[beat];

    a_burst_hold: assert property (@(posedge clk) disable iff (resetn)
        creq_valid && !(cresp_ready && cresp_last) |=> creq_valid);

    // memory must close every burst after exactly one line
    a_burst_length: assert property (@(posedge clk) disable iff (resetn)
        creq_valid && cresp_ready && cresp_last |-> beat == offset_t'(`DC_LINE_WORDS - 1));

endmodule

`default_nettype wire

// ==== verilog/dcache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_data_array (
    input  wire logic                clk,
    input  wire logic                a_en,
    input  wire dcache_pkg::way_t    a_way,
    input  wire dcache_pkg::index_t  a_index,
    input  wire dcache_pkg::offset_t a_offset,
    input  wire dcache_pkg::strobe_t a_strobe,
    input  wire dcache_pkg::word_t   a_wdata,
    output dcache_pkg::word_t        a_rdata,
    input  wire logic                b_en,
    input  wire dcache_pkg::way_t    b_way,
    input  wire dcache_pkg::index_t  b_index,
    input  wire dcache_pkg::offset_t b_offset,
    input  wire dcache_pkg::strobe_t b_strobe,
    input  wire dcache_pkg::word_t   b_wdata,
    output dcache_pkg::word_t        b_rdata
);
    import dcache_pkg::*;

    localparam int ADDR_BITS = `DC_WAY_BITS + `DC_INDEX_BITS + `DC_OFFSET_BITS;

    word_t                mem [`DC_WAYS * `DC_SETS * `DC_LINE_WORDS];
    logic [ADDR_BITS-1:0] a_addr;
    logic [ADDR_BITS-1:0] b_addr;

    assign a_addr = {a_way, a_index, a_offset};
    assign b_addr = {b_way, b_index, b_offset};

    // reads return the word as it was before this edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < `DC_STRB_BITS; i++) begin
            if (a_en && a_strobe[i]) begin
                mem[a_addr][i*8 +: 8] <= a_wdata[i*8 +: 8];
            end
            if (b_en && b_strobe[i]) begin
                mem[b_addr][i*8 +: 8] <= b_wdata[i*8 +: 8];
            end
        end
        if (a_en) begin
            a_rdata <= mem[a_addr];
        end
        if (b_en) begin
            b_rdata <= mem[b_addr];
        end
    end

    // core hits and refill beats never collide on one word
    a_no_dual_write: assert property (@(posedge clk)
        !(a_en && b_en && (|a_strobe) && (|b_strobe) && (a_addr == b_addr)));

endmodule

`default_nettype wire

// ==== verilog/dcache_plru.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_plru (
    input  wire logic               clk,
    input  wire logic               resetn,
    input  wire dcache_pkg::index_t index,
    input  wire logic               touch,
    input  wire dcache_pkg::way_t   touch_way,
    output dcache_pkg::way_t        victim_way
);
    import dcache_pkg::*;

    plru_t [`DC_SETS-1:0] plru_q;
    plru_t                cur;
    plru_t                nxt;

    assign cur = plru_q[index];

    // node n has children 2n+1 (low half) and 2n+2 (high half)
    // a bit of 0 points the victim into the low half
    always_comb begin
        int node;
        node = 0;
        victim_way = '0;
        for (int lvl = 0; lvl < `DC_WAY_BITS; lvl++) begin
            victim_way[`DC_WAY_BITS-1-lvl] = cur[node];
            node = 2 * node + 1 + int'(cur[node]);
        end
    end

    // flip every node on the path to point away from the used way
    always_comb begin
        int   node;
        logic b;
        nxt  = cur;
        node = 0;
        for (int lvl = 0; lvl < `DC_WAY_BITS; lvl++) begin
            b         = touch_way[`DC_WAY_BITS-1-lvl];
            nxt[node] = ~b;
            node      = 2 * node + 1 + int'(b);
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            plru_q <= '0;
        end else if (touch) begin
            plru_q[index] <= nxt;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_tag_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_tag_lookup (
    input  wire logic               clk,
    input  wire logic               resetn,
    input  wire logic               req_valid,
    input  wire dcache_pkg::tag_t   req_tag,
    input  wire dcache_pkg::index_t req_index,
    input  wire logic               req_write,
    input  wire logic               engine_idle,
    input  wire logic               refill_done,
    input  wire dcache_pkg::way_t   victim_way,
    output logic                    hit,
    output dcache_pkg::way_t        hit_way,
    output logic                    miss,
    output logic                    victim_dirty,
    output dcache_pkg::tag_t        victim_tag
);
    import dcache_pkg::*;

    logic [`DC_SETS-1:0][`DC_WAYS-1:0] valid_q;
    logic [`DC_SETS-1:0][`DC_WAYS-1:0] dirty_q;
    tag_t                              tag_mem [`DC_SETS][`DC_WAYS];
    logic [`DC_WAYS-1:0]               hit_vec;
    logic                              accept_write;

    // all ways compared in parallel
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_vec[w] = valid_q[req_index][w] && (tag_mem[req_index][w] == req_tag);
        end
    end

    // at most one bit set, so an or of indices encodes it
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way = hit_way | way_t'(w);
            end
        end
    end

    assign hit          = req_valid && (|hit_vec);
    assign miss         = req_valid && !(|hit_vec) && engine_idle;
    assign victim_dirty = valid_q[req_index][victim_way] && dirty_q[req_index][victim_way];
    assign victim_tag   = tag_mem[req_index][victim_way];
    assign accept_write = hit && engine_idle && req_write;

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (refill_done) begin
                valid_q[req_index][victim_way] <= 1'b1;
                dirty_q[req_index][victim_way] <= 1'b0;
            end
            if (accept_write) begin
                dirty_q[req_index][hit_way] <= 1'b1;
            end
        end
    end

    // new tag goes in with the last refill beat
    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_mem[req_index][victim_way] <= req_tag;
        end
    end

    a_hit_onehot: assert property (@(posedge clk) disable iff (resetn)
        req_valid |-> $onehot0(hit_vec));

    // held request must hit right after its line lands
    a_hit_after_refill: assert property (@(posedge clk) disable iff (resetn)
        refill_done |=> hit);

endmodule

`default_nettype wire

// ==== verilog/dcache_pkg.sv ====
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

    // address fields
    typedef logic [`DC_TAG_BITS-1:0]    tag_t;
    typedef logic [`DC_INDEX_BITS-1:0]  index_t;
    typedef logic [`DC_OFFSET_BITS-1:0] offset_t;
    typedef logic [`DC_WAY_BITS-1:0]    way_t;

    // data path
    typedef logic [`DC_WORD_BITS-1:0]   word_t;
    typedef logic [`DC_STRB_BITS-1:0]   strobe_t;

    // one bit per internal tree node
    typedef logic [`DC_WAYS-2:0]        plru_t;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_READOUT,
        MS_WRITEBACK,
        MS_FETCH
    } miss_state_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cache geometry
`define DC_WAYS         4
`define DC_SETS         16
`define DC_LINE_WORDS   4

`define DC_WAY_BITS     2
`define DC_INDEX_BITS   4
`define DC_OFFSET_BITS  2

// 32-bit address minus index, offset and byte select
`define DC_TAG_BITS     (32 - `DC_INDEX_BITS - `DC_OFFSET_BITS - 2)

`define DC_WORD_BITS    32
`define DC_STRB_BITS    4

`endif
